/* hdl/gda_settings.svh */
`ifndef GDA_SETTINGS_SVH
`define GDA_SETTINGS_SVH

////////////////////////////////////////
// Adder geometry
////////////////////////////////////////

// Operand width in bits
`define GDA_WIDTH 16

// Width of one sum segment
`define GDA_SEG 4

// Carry lookahead window below each segment, in bits.
// Multiple of GDA_SEG, no larger than GDA_WIDTH
`define GDA_PRED 8

`endif

/* hdl/gda_pkg.sv */
`include "gda_settings.svh"

package gda_pkg;

    ////////////////////////////////////////
    // Input side
    ////////////////////////////////////////

    // One operand pair
    typedef struct packed {
        logic [`GDA_WIDTH-1:0] a;
        logic [`GDA_WIDTH-1:0] b;
    } gda_operands_t;

    ////////////////////////////////////////
    // Output side
    ////////////////////////////////////////

    // Both sums carry the final carry-out as MSB
    typedef struct packed {
        logic [`GDA_WIDTH:0] approx;
        logic [`GDA_WIDTH:0] exact;
        // exact - approx, never negative
        logic [`GDA_WIDTH:0] err_dist;
    } gda_result_t;

    // Running error statistics
    typedef struct packed {
        // Results with non-zero error, saturating
        logic [31:0]         err_count;
        // Largest error distance seen
        logic [`GDA_WIDTH:0] max_err;
    } gda_stats_t;

endpackage

/* hdl/gda_carry_predict.sv */
`timescale 1ns/1ps
`include "gda_settings.svh"

module gda_carry_predict (
    input  logic [`GDA_WIDTH-1:0]          gen,
    input  logic [`GDA_WIDTH-1:0]          prop,
    output logic [`GDA_WIDTH/`GDA_SEG-1:0] seg_cin
);

    localparam int SEG  = `GDA_SEG;
    localparam int NSEG = `GDA_WIDTH / `GDA_SEG;
    // Segments inside one lookahead window
    localparam int WSEG = `GDA_PRED / `GDA_SEG;

    logic [NSEG-1:0] blk_g;
    logic [NSEG-1:0] blk_p;

    // Carry out of the window just below segment k.
    // Window starts with carry-in zero; anything from further
    // below is dropped
    function automatic logic window_carry(
        input logic [NSEG-1:0] g,
        input logic [NSEG-1:0] p,
        input int              k
    );
        logic c;
        c = 1'b0;
        for (int j = 0; j < NSEG; j++) begin
            // Only segments inside the window
            if ((j < k) && (j + WSEG >= k)) begin
                c = g[j] | (p[j] & c);
            end
        end
        return c;
    endfunction

    ////////////////////////////////////////
    // Block generate / propagate
    ////////////////////////////////////////

    always_comb begin
        for (int s = 0; s < NSEG; s++) begin
            blk_g[s] = 1'b0;
            blk_p[s] = 1'b1;
            // Ripple from LSB of the segment upwards
            for (int i = 0; i < SEG; i++) begin
                blk_g[s] = gen[s*SEG + i] | (prop[s*SEG + i] & blk_g[s]);
                blk_p[s] = blk_p[s] & prop[s*SEG + i];
            end
        end
    end

    ////////////////////////////////////////
    // Predicted carry-in per segment
    ////////////////////////////////////////

    // Segment 0 comes out as zero, empty window
    for (genvar k = 0; k < NSEG; k++) begin : g_seg_cin
        assign seg_cin[k] = window_carry(blk_g, blk_p, k);
    end

endmodule

/* hdl/gda_adder.sv */
`timescale 1ns/1ps
`include "gda_settings.svh"

module gda_adder (
    input  gda_pkg::gda_operands_t ops,
    output logic [`GDA_WIDTH:0]    sum
);

    localparam int W    = `GDA_WIDTH;
    localparam int SEG  = `GDA_SEG;
    localparam int NSEG = `GDA_WIDTH / `GDA_SEG;

    // Bitwise generate and propagate
    logic [W-1:0] gen;
    logic [W-1:0] prop;

    // Predicted carry into each segment
    logic [NSEG-1:0] seg_cin;

    // Per-segment sums, MSB is the segment carry-out
    logic [NSEG-1:0][SEG:0] seg_sum;

    assign gen  = ops.a & ops.b;
    assign prop = ops.a ^ ops.b;

    gda_carry_predict gda_carry_predict_inst (
        .gen     (gen),
        .prop    (prop),
        .seg_cin (seg_cin)
    );

    ////////////////////////////////////////
    // Segment adders
    ////////////////////////////////////////

    for (genvar s = 0; s < NSEG; s++) begin : g_seg
        logic [SEG:0] op_a;
        logic [SEG:0] op_b;
        logic [SEG:0] cin;

        assign op_a = {1'b0, ops.a[s*SEG +: SEG]};
        assign op_b = {1'b0, ops.b[s*SEG +: SEG]};
        assign cin  = {{SEG{1'b0}}, seg_cin[s]};

        assign seg_sum[s] = op_a + op_b + cin;
    end

    ////////////////////////////////////////
    // Result assembly
    ////////////////////////////////////////

    // Lower segments drop their carry-out; the predictor covers it
    always_comb begin
        for (int s = 0; s < NSEG; s++) begin
            sum[s*SEG +: SEG] = seg_sum[s][SEG-1:0];
        end
        // Top segment keeps its carry-out as sum MSB
        sum[W] = seg_sum[NSEG-1][SEG];
    end

endmodule

/* hdl/gda_error_monitor.sv */
`timescale 1ns/1ps

module gda_error_monitor (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                res_valid,
    input  gda_pkg::gda_result_t res,
    input  logic                stats_clear,
    output gda_pkg::gda_stats_t stats
);

    import gda_pkg::*;

    gda_stats_t stats_next;

    // Current result is off from the exact sum
    logic err_seen;
    // Counter already at its ceiling
    logic count_full;
    // Current distance beats the stored maximum
    logic new_max;

    ////////////////////////////////////////
    // Per-result flags
    ////////////////////////////////////////

    assign err_seen   = |res.err_dist;
    assign count_full = &stats.err_count;
    assign new_max    = res.err_dist > stats.max_err;

    ////////////////////////////////////////
    // Next statistics
    ////////////////////////////////////////

    always_comb begin
        stats_next = stats;

        if (stats_clear) begin
            // Clear wins over a simultaneous result
            stats_next = '0;
        end else if (res_valid) begin
            if (err_seen && !count_full) begin
                stats_next.err_count = stats.err_count + 32'd1;
            end
            if (new_max) begin
                stats_next.max_err = res.err_dist;
            end
        end
    end

    ////////////////////////////////////////
    // Statistics register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stats <= '0;
        end else begin
            stats <= stats_next;
        end
    end

endmodule

/* hdl/gda_top.sv */
`timescale 1ns/1ps
`include "gda_settings.svh"

module gda_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  gda_pkg::gda_operands_t ops,
    input  logic                  stats_clear,
    output logic                  out_valid,
    output gda_pkg::gda_result_t  res,
    output gda_pkg::gda_stats_t   stats
);

    import gda_pkg::*;

    localparam int W = `GDA_WIDTH;

    // Stage 1
    gda_operands_t ops_q;
    logic          valid_q;

    // Combinational sums from stage 1
    logic [W:0]  approx_sum;
    logic [W:0]  exact_sum;
    gda_result_t res_d;

    ////////////////////////////////////////
    // Stage 1, operand capture
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // Operands only move on a strobe
    always_ff @(posedge clk) begin
        if (in_valid) begin
            ops_q <= ops;
        end
    end

    ////////////////////////////////////////
    // Approximate and exact sums
    ////////////////////////////////////////

    gda_adder gda_adder_inst (
        .ops (ops_q),
        .sum (approx_sum)
    );

    // Full-width reference sum
    assign exact_sum = {1'b0, ops_q.a} + {1'b0, ops_q.b};

    always_comb begin
        res_d.approx   = approx_sum;
        res_d.exact    = exact_sum;
        // Missed carries only lower approx, so this stays non-negative
        res_d.err_dist = exact_sum - approx_sum;
    end

    ////////////////////////////////////////
    // Stage 2, result register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            res       <= '0;
        end else begin
            out_valid <= valid_q;
            if (valid_q) begin
                res <= res_d;
            end
        end
    end

    // Monitor watches the registered result
    gda_error_monitor gda_error_monitor_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .res_valid   (out_valid),
        .res         (res),
        .stats_clear (stats_clear),
        .stats       (stats)
    );

endmodule

/* tb/gda_tb.sv */
`timescale 1ns/1ps
`include "gda_settings.svh"

module gda_tb;

    import gda_pkg::*;

    localparam int W      = `GDA_WIDTH;
    localparam int SEG    = `GDA_SEG;
    localparam int PRED   = `GDA_PRED;
    localparam int NSEG   = `GDA_WIDTH / `GDA_SEG;
    // Lowest bit of the window feeding the top segment
    localparam int WIN_LO = W - SEG - PRED;

    localparam int          CLK_HALF       = 4;
    localparam int          RESET_CYCLES   = 10;
    localparam int          TABLE_LEN      = 13;
    localparam int          RAND_COUNT     = 200;
    localparam int          TIMEOUT_CYCLES = TABLE_LEN + RAND_COUNT + 50;
    localparam logic [31:0] SEED           = 32'h5cbd_4cfa;

    typedef struct packed {
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W:0]   approx;
    } table_entry_t;

    // Operands and the approximate sum worked out by hand from the window rule
    table_entry_t stim_table [TABLE_LEN] = '{
        '{16'h0000, 16'h0000, 17'h00000},
        '{16'h000F, 16'h0001, 17'h00010},
        '{16'h00FF, 16'h0001, 17'h00100},
        '{16'hFFFF, 16'hFFFF, 17'h1FFFE},
        '{16'h0088, 16'h0088, 17'h00110},
        '{16'h1234, 16'h4321, 17'h05555},
        '{16'h8000, 16'h8000, 17'h10000},
        // Generate sits inside the window, so still exact
        '{16'hFFF0, 16'h0010, 17'h10000},
        // Carry from segment 0 runs through the whole window
        '{16'h0FFF, 16'h0001, 17'h00000},
        '{16'hF00F, 16'h0FF1, 17'h0F000},
        '{16'h0801, 16'h07FF, 17'h00000},
        '{16'h7FFF, 16'h0001, 17'h07000},
        '{16'hFFFF, 16'h0001, 17'h0F000}
    };

    logic          clk;
    logic          arst_n;
    logic          in_valid;
    gda_operands_t ops;
    logic          stats_clear;
    logic          out_valid;
    gda_result_t   res;
    gda_stats_t    stats;

    // Scoreboard
    gda_result_t exp_q [$];
    int          due_q [$];
    gda_result_t exp_res;
    int          exp_due;
    gda_stats_t  model_stats;

    int           cycle;
    int           tbl_errors;
    logic [W:0]   tbl_max;
    logic [W-1:0] rand_a;
    logic [W-1:0] rand_b;
    int unsigned  seed_val;

    gda_top gda_top_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .ops         (ops),
        .stats_clear (stats_clear),
        .out_valid   (out_valid),
        .res         (res),
        .stats       (stats)
    );

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Each segment takes the carry out of the bits below it, at most PRED of them
    function automatic logic [W:0] model_approx(input logic [W-1:0] a, input logic [W-1:0] b);
        logic [W:0]   result;
        logic [W:0]   mask;
        logic [W:0]   win_sum;
        logic [SEG:0] seg;
        logic         cin;
        int           lo;
        int           width;
        result = '0;
        for (int k = 0; k < NSEG; k++) begin
            lo = k * SEG - PRED;
            if (lo < 0) begin
                lo = 0;
            end
            width   = k * SEG - lo;
            mask    = ({{W{1'b0}}, 1'b1} << width) - 1'b1;
            win_sum = ((a >> lo) & mask) + ((b >> lo) & mask);
            cin     = win_sum[width];
            seg     = a[k*SEG +: SEG] + b[k*SEG +: SEG] + cin;
            result[k*SEG +: SEG] = seg[SEG-1:0];
            if (k == NSEG - 1) begin
                result[W] = seg[SEG];
            end
        end
        return result;
    endfunction

    function automatic gda_result_t expected_result(input logic [W-1:0] a, input logic [W-1:0] b,
                                                    input logic [W:0] approx);
        gda_result_t r;
        r.approx   = approx;
        r.exact    = {1'b0, a} + {1'b0, b};
        r.err_dist = r.exact - approx;
        return r;
    endfunction

    ////////////////////////////////////////
    // Checks and stimulus helpers
    ////////////////////////////////////////

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            report_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h",
                                     name, got, expected));
        end
    endtask

    task automatic drive_pair(input logic [W-1:0] a, input logic [W-1:0] b,
                              input logic [W:0] approx);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        ops.a    = a;
        ops.b    = b;
        exp_q.push_back(expected_result(a, b, approx));
        // Result registered two edges after the sampling edge's launch
        due_q.push_back(cycle + 2);
    endtask

    task automatic wait_drain();
        while (exp_q.size() > 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    ////////////////////////////////////////
    // Clock, cycle count and timeout
    ////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        report_failure($sformatf("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES));
    end

    ////////////////////////////////////////
    // Output checker at mid-cycle
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (arst_n === 1'b1) begin
            check_value("stats.err_count", stats.err_count, model_stats.err_count);
            check_value("stats.max_err", stats.max_err, model_stats.max_err);
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    report_failure("out_valid went high with no result outstanding");
                end
                exp_res = exp_q.pop_front();
                exp_due = due_q.pop_front();
                check_value("result_cycle", cycle, exp_due);
                check_value("res.approx", res.approx, exp_res.approx);
                check_value("res.exact", res.exact, exp_res.exact);
                check_value("res.err_dist", res.err_dist, exp_res.err_dist);
            end else if (due_q.size() > 0 && due_q[0] <= cycle) begin
                report_failure("A result did not arrive in its expected cycle");
            end
            // Stats follow one edge later and clear wins
            if (stats_clear) begin
                model_stats = '0;
            end else if (out_valid) begin
                if (exp_res.err_dist != '0 && model_stats.err_count != 32'hFFFF_FFFF) begin
                    model_stats.err_count = model_stats.err_count + 32'd1;
                end
                if (exp_res.err_dist > model_stats.max_err) begin
                    model_stats.max_err = exp_res.err_dist;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        seed_val    = $urandom(SEED);
        cycle       = 0;
        model_stats = '0;
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        ops         = '0;
        stats_clear = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(posedge clk);
        #1;
        check_value("out_valid", out_valid, 1'b0);
        check_value("stats.err_count", stats.err_count, 32'd0);
        check_value("stats.max_err", stats.max_err, '0);

        // Model must agree with the hand-worked table
        tbl_errors = 0;
        tbl_max    = '0;
        for (int i = 0; i < TABLE_LEN; i++) begin
            check_value($sformatf("model_approx[%0d]", i),
                        model_approx(stim_table[i].a, stim_table[i].b), stim_table[i].approx);
            exp_res = expected_result(stim_table[i].a, stim_table[i].b, stim_table[i].approx);
            if (exp_res.err_dist != '0) begin
                tbl_errors++;
            end
            if (exp_res.err_dist > tbl_max) begin
                tbl_max = exp_res.err_dist;
            end
        end

        // Directed table back to back
        for (int i = 0; i < TABLE_LEN; i++) begin
            drive_pair(stim_table[i].a, stim_table[i].b, stim_table[i].approx);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        wait_drain();
        @(posedge clk);
        #1;
        check_value("stats.err_count", stats.err_count, tbl_errors);
        check_value("stats.max_err", stats.max_err, tbl_max);

        // Clear between phases
        stats_clear = 1'b1;
        @(posedge clk);
        #1;
        stats_clear = 1'b0;
        check_value("stats.err_count", stats.err_count, 32'd0);
        check_value("stats.max_err", stats.max_err, '0);

        // Random phase with one clear pulse halfway while results stream
        for (int i = 0; i < RAND_COUNT; i++) begin
            rand_a = $urandom;
            rand_b = $urandom;
            // Make the top window all-propagate now and then
            if ($urandom % 4 == 0) begin
                rand_b[WIN_LO +: PRED] = ~rand_a[WIN_LO +: PRED];
            end
            drive_pair(rand_a, rand_b, model_approx(rand_a, rand_b));
            stats_clear = (i == RAND_COUNT / 2);
        end
        @(posedge clk);
        #1;
        in_valid    = 1'b0;
        stats_clear = 1'b0;
        wait_drain();
        @(posedge clk);
        @(negedge clk);
        #1;

        $display("test passed");
        $finish;
    end

endmodule

/* all.f */
+incdir+hdl
hdl/gda_pkg.sv
hdl/gda_carry_predict.sv
hdl/gda_adder.sv
hdl/gda_error_monitor.sv
hdl/gda_top.sv
tb/gda_tb.sv

/* Bender.yml */
package:
  name: gda_adder

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/gda_pkg.sv
      - hdl/gda_carry_predict.sv
      - hdl/gda_adder.sv
      - hdl/gda_error_monitor.sv
      - hdl/gda_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/gda_tb.sv
